// ==== design/idma_rd_pkg.sv ====
package idma_rd_pkg;

    localparam int ADDR_W     = 32;
    localparam int CNT_W      = 16;
    localparam int REG_ADDR_W = 3;

    // register map
    localparam logic [REG_ADDR_W-1:0] REG_CTRL   = 3'd0;
    localparam logic [REG_ADDR_W-1:0] REG_FMAPA  = 3'd1;
    localparam logic [REG_ADDR_W-1:0] REG_FMAPB  = 3'd2;
    localparam logic [REG_ADDR_W-1:0] REG_GAP    = 3'd3;
    localparam logic [REG_ADDR_W-1:0] REG_LOOP   = 3'd4;
    localparam logic [REG_ADDR_W-1:0] REG_STATUS = 3'd5;

    // ctrl fields, start is self-clearing
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_MODE_BIT  = 1;
    localparam int STATUS_BUSY_BIT = 0;

    localparam int ADDR_FIFO_DEPTH = 8;
    localparam int AFIFO_PTR_W     = $clog2(ADDR_FIFO_DEPTH);
    localparam int AFIFO_CNT_W     = $clog2(ADDR_FIFO_DEPTH + 1);

    typedef enum logic [2:0] {RESI_IDLE, RESI_TRANS_FMAPA, RESI_TRANS_FMAPB} resi_state_e;

    typedef enum logic {LIN_IDLE, LIN_TRANS} lin_state_e;

    typedef enum logic {
        RD_MODE_LINEAR = 1'b0,
        RD_MODE_RESI   = 1'b1
    } rd_mode_e;

endpackage

// ==== design/idma_rd_cfg_regs.sv ====
`timescale 1ns/1ps

module idma_rd_cfg_regs
    import idma_rd_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cfg_wr,
    input  logic [REG_ADDR_W-1:0] cfg_addr,
    input  logic [ADDR_W-1:0]     cfg_wdata,
    output logic [ADDR_W-1:0]     cfg_rdata,
    input  logic                  resi_busy,
    input  logic                  lin_busy,
    output logic                  rd_req,
    output logic                  rd_resi_mode,
    output logic                  rd_lin_mode,
    output logic [ADDR_W-1:0]     rd_fmapA_addr,
    output logic [ADDR_W-1:0]     rd_fmapB_addr,
    output logic [CNT_W-1:0]      rd_addr_gap,
    output logic [CNT_W-1:0]      rd_loop_num
);

    rd_mode_e mode_q;
    logic     busy_any;
    logic     start_wr;
    logic     desc_wr;

    // rd_req counts as busy, generators raise busy one cycle later
    assign busy_any = resi_busy | lin_busy | rd_req;

    assign start_wr = cfg_wr && (cfg_addr == REG_CTRL) && cfg_wdata[CTRL_START_BIT];
    // descriptor frozen while a transfer runs
    assign desc_wr  = cfg_wr && !busy_any;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_req <= 1'b0;
        end else begin
            rd_req <= start_wr && !busy_any;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q        <= RD_MODE_LINEAR;
            rd_fmapA_addr <= '0;
            rd_fmapB_addr <= '0;
            rd_addr_gap   <= '0;
            rd_loop_num   <= '0;
        end else if (desc_wr) begin
            case (cfg_addr)
                REG_CTRL:  mode_q        <= rd_mode_e'(cfg_wdata[CTRL_MODE_BIT]);
                REG_FMAPA: rd_fmapA_addr <= cfg_wdata;
                REG_FMAPB: rd_fmapB_addr <= cfg_wdata;
                REG_GAP:   rd_addr_gap   <= cfg_wdata[CNT_W-1:0];
                REG_LOOP:  rd_loop_num   <= cfg_wdata[CNT_W-1:0];
                default: ;
            endcase
        end
    end

    assign rd_resi_mode = (mode_q == RD_MODE_RESI);
    assign rd_lin_mode  = (mode_q == RD_MODE_LINEAR);

    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            REG_CTRL:   cfg_rdata[CTRL_MODE_BIT] = mode_q;
            REG_FMAPA:  cfg_rdata = rd_fmapA_addr;
            REG_FMAPB:  cfg_rdata = rd_fmapB_addr;
            REG_GAP:    cfg_rdata = {{(ADDR_W-CNT_W){1'b0}}, rd_addr_gap};
            REG_LOOP:   cfg_rdata = {{(ADDR_W-CNT_W){1'b0}}, rd_loop_num};
            REG_STATUS: cfg_rdata[STATUS_BUSY_BIT] = busy_any;
            default:    cfg_rdata = '0;
        endcase
    end

endmodule

// ==== design/idma_rd_sync_resi_raddr_gen.sv ====
`timescale 1ns/1ps

module idma_rd_sync_resi_raddr_gen
    import idma_rd_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rd_resi_mode,
    input  logic [ADDR_W-1:0] rd_resi_fmapA_addr,
    input  logic [ADDR_W-1:0] rd_resi_fmapB_addr,
    input  logic [CNT_W-1:0]  rd_resi_addr_gap,
    input  logic [CNT_W-1:0]  rd_resi_loop_num,
    input  logic              rd_req,
    input  logic              rd_afifo_full_s,
    output logic              rd_resi_req,
    output logic [ADDR_W-1:0] rd_resi_addr,
    output logic              resi_busy
);

    resi_state_e       resi_cs;
    resi_state_e       resi_ns;
    logic [CNT_W-1:0]  rd_resi_loop_cnt;
    logic [ADDR_W-1:0] resi_fmapA_addr;
    logic [ADDR_W-1:0] resi_fmapB_addr;
    logic [ADDR_W-1:0] gap_ext;
    logic [CNT_W-1:0]  loop_num_m1;
    logic [CNT_W-1:0]  loop_num_m2;
    logic              resi_start;
    logic              resi_addr_last;

    assign gap_ext     = {{(ADDR_W-CNT_W){1'b0}}, rd_resi_addr_gap};
    assign loop_num_m1 = rd_resi_loop_num - 1'b1;
    // wraps for n = 1, so no extra +1 then
    assign loop_num_m2 = rd_resi_loop_num - 2'd2;

    assign resi_start  = rd_req && rd_resi_mode;
    assign resi_busy   = (resi_cs != RESI_IDLE);
    assign rd_resi_req = resi_busy && !rd_afifo_full_s;

    assign resi_addr_last = rd_resi_req && (resi_cs == RESI_TRANS_FMAPB) &&
                            (rd_resi_loop_cnt == loop_num_m1);

    always_ff @(posedge clk) begin
        if (resi_start) begin
            resi_fmapA_addr <= rd_resi_fmapA_addr;
        end else if (rd_resi_req && (resi_cs == RESI_TRANS_FMAPA)) begin
            resi_fmapA_addr <= resi_fmapA_addr + gap_ext;
        end
    end

    // last B address of the transfer gets the extra byte
    always_ff @(posedge clk) begin
        if (resi_start) begin
            resi_fmapB_addr <= rd_resi_fmapB_addr;
        end else if (rd_resi_req && (resi_cs == RESI_TRANS_FMAPB)) begin
            if (rd_resi_loop_cnt == loop_num_m2) begin
                resi_fmapB_addr <= resi_fmapB_addr + gap_ext + 1'b1;
            end else begin
                resi_fmapB_addr <= resi_fmapB_addr + gap_ext;
            end
        end
    end

    // one count per A/B pair
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_resi_loop_cnt <= '0;
        end else if (resi_start || resi_addr_last) begin
            rd_resi_loop_cnt <= '0;
        end else if (rd_resi_req && (resi_cs == RESI_TRANS_FMAPB)) begin
            rd_resi_loop_cnt <= rd_resi_loop_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resi_cs <= RESI_IDLE;
        end else begin
            resi_cs <= resi_ns;
        end
    end

    always_comb begin
        resi_ns = resi_cs;
        case (resi_cs)
            RESI_IDLE: begin
                if (resi_start) begin
                    resi_ns = RESI_TRANS_FMAPA;
                end
            end
            RESI_TRANS_FMAPA: begin
                if (rd_resi_req) begin
                    resi_ns = RESI_TRANS_FMAPB;
                end
            end
            RESI_TRANS_FMAPB: begin
                if (resi_addr_last) begin
                    resi_ns = RESI_IDLE;
                end else if (rd_resi_req) begin
                    resi_ns = RESI_TRANS_FMAPA;
                end
            end
            default: resi_ns = RESI_IDLE;
        endcase
    end

    always_comb begin
        case (resi_cs)
            RESI_TRANS_FMAPA: rd_resi_addr = resi_fmapA_addr;
            RESI_TRANS_FMAPB: rd_resi_addr = resi_fmapB_addr;
            default:          rd_resi_addr = '0;
        endcase
    end

    // stalled address survives until the FIFO drains
    a_hold_on_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        resi_busy && rd_afifo_full_s |=> $stable(rd_resi_addr)
    );

endmodule

// ==== design/idma_rd_lin_raddr_gen.sv ====
`timescale 1ns/1ps

module idma_rd_lin_raddr_gen
    import idma_rd_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rd_lin_mode,
    input  logic [ADDR_W-1:0] rd_lin_base_addr,
    input  logic [CNT_W-1:0]  rd_lin_addr_gap,
    input  logic [CNT_W-1:0]  rd_lin_loop_num,
    input  logic              rd_req,
    input  logic              rd_afifo_full_s,
    output logic              rd_lin_req,
    output logic [ADDR_W-1:0] rd_lin_addr,
    output logic              lin_busy
);

    lin_state_e       lin_cs;
    lin_state_e       lin_ns;
    logic [CNT_W-1:0] lin_cnt;
    logic             lin_start;
    logic             lin_last;

    assign lin_start  = rd_req && rd_lin_mode;
    assign lin_busy   = (lin_cs == LIN_TRANS);
    assign rd_lin_req = lin_busy && !rd_afifo_full_s;
    assign lin_last   = rd_lin_req && (lin_cnt == rd_lin_loop_num - 1'b1);

    always_ff @(posedge clk) begin
        if (lin_start) begin
            rd_lin_addr <= rd_lin_base_addr;
        end else if (rd_lin_req) begin
            rd_lin_addr <= rd_lin_addr + {{(ADDR_W-CNT_W){1'b0}}, rd_lin_addr_gap};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lin_cnt <= '0;
        end else if (lin_start) begin
            lin_cnt <= '0;
        end else if (rd_lin_req) begin
            lin_cnt <= lin_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lin_cs <= LIN_IDLE;
        end else begin
            lin_cs <= lin_ns;
        end
    end

    always_comb begin
        lin_ns = lin_cs;
        case (lin_cs)
            LIN_IDLE:  if (lin_start) lin_ns = LIN_TRANS;
            LIN_TRANS: if (lin_last) lin_ns = LIN_IDLE;
            default:   lin_ns = LIN_IDLE;
        endcase
    end

    // first strobe comes a cycle after rd_req, never with it
    a_no_req_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_req |-> !rd_lin_req
    );

endmodule

// ==== design/idma_rd_addr_fifo.sv ====
`timescale 1ns/1ps

module idma_rd_addr_fifo
    import idma_rd_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_a,
    input  logic [ADDR_W-1:0] wr_a_data,
    input  logic              wr_b,
    input  logic [ADDR_W-1:0] wr_b_data,
    output logic              full,
    input  logic              addr_pop,
    output logic              addr_valid,
    output logic [ADDR_W-1:0] addr_data
);

    logic [ADDR_W-1:0]      mem [ADDR_FIFO_DEPTH];
    logic [AFIFO_PTR_W-1:0] wr_ptr;
    logic [AFIFO_PTR_W-1:0] rd_ptr;
    logic [AFIFO_CNT_W-1:0] count;
    logic [ADDR_W-1:0]      wr_data;
    logic                   wr_en;
    logic                   rd_en;

    assign wr_en   = (wr_a || wr_b) && !full;
    assign rd_en   = addr_pop && addr_valid;
    assign wr_data = wr_a ? wr_a_data : wr_b_data;

    assign full       = (count == AFIFO_CNT_W'(ADDR_FIFO_DEPTH));
    assign addr_valid = (count != '0);
    assign addr_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // only one generator runs per transfer
    a_one_writer: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wr_a && wr_b)
    );

    a_no_write_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_a || wr_b) |-> !full
    );

endmodule

// ==== design/idma_rd_addr_top.sv ====
`timescale 1ns/1ps

module idma_rd_addr_top
    import idma_rd_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cfg_wr,
    input  logic [REG_ADDR_W-1:0] cfg_addr,
    input  logic [ADDR_W-1:0]     cfg_wdata,
    output logic [ADDR_W-1:0]     cfg_rdata,
    input  logic                  addr_pop,
    output logic                  addr_valid,
    output logic [ADDR_W-1:0]     addr_data
);

    logic              rd_req;
    logic              rd_resi_mode;
    logic              rd_lin_mode;
    logic [ADDR_W-1:0] rd_fmapA_addr;
    logic [ADDR_W-1:0] rd_fmapB_addr;
    logic [CNT_W-1:0]  rd_addr_gap;
    logic [CNT_W-1:0]  rd_loop_num;
    logic              resi_busy;
    logic              lin_busy;
    logic              rd_resi_req;
    logic [ADDR_W-1:0] rd_resi_addr;
    logic              rd_lin_req;
    logic [ADDR_W-1:0] rd_lin_addr;
    logic              afifo_full;

    idma_rd_cfg_regs i_cfg_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_wr        (cfg_wr),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata),
        .resi_busy     (resi_busy),
        .lin_busy      (lin_busy),
        .rd_req        (rd_req),
        .rd_resi_mode  (rd_resi_mode),
        .rd_lin_mode   (rd_lin_mode),
        .rd_fmapA_addr (rd_fmapA_addr),
        .rd_fmapB_addr (rd_fmapB_addr),
        .rd_addr_gap   (rd_addr_gap),
        .rd_loop_num   (rd_loop_num)
    );

    idma_rd_sync_resi_raddr_gen i_resi_gen (
        .clk                (clk),
        .rst_n              (rst_n),
        .rd_resi_mode       (rd_resi_mode),
        .rd_resi_fmapA_addr (rd_fmapA_addr),
        .rd_resi_fmapB_addr (rd_fmapB_addr),
        .rd_resi_addr_gap   (rd_addr_gap),
        .rd_resi_loop_num   (rd_loop_num),
        .rd_req             (rd_req),
        .rd_afifo_full_s    (afifo_full),
        .rd_resi_req        (rd_resi_req),
        .rd_resi_addr       (rd_resi_addr),
        .resi_busy          (resi_busy)
    );

    // linear mode walks fmap A only
    idma_rd_lin_raddr_gen i_lin_gen (
        .clk              (clk),
        .rst_n            (rst_n),
        .rd_lin_mode      (rd_lin_mode),
        .rd_lin_base_addr (rd_fmapA_addr),
        .rd_lin_addr_gap  (rd_addr_gap),
        .rd_lin_loop_num  (rd_loop_num),
        .rd_req           (rd_req),
        .rd_afifo_full_s  (afifo_full),
        .rd_lin_req       (rd_lin_req),
        .rd_lin_addr      (rd_lin_addr),
        .lin_busy         (lin_busy)
    );

    idma_rd_addr_fifo i_addr_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_a       (rd_resi_req),
        .wr_a_data  (rd_resi_addr),
        .wr_b       (rd_lin_req),
        .wr_b_data  (rd_lin_addr),
        .full       (afifo_full),
        .addr_pop   (addr_pop),
        .addr_valid (addr_valid),
        .addr_data  (addr_data)
    );

endmodule

// ==== dv/idma_rd_tb.sv ====
`timescale 1ns/1ps

module idma_rd_tb
    import idma_rd_pkg::*;
();

    localparam int WAIT_LIMIT = 2000;

    logic                  clk;
    logic                  rst_n;
    logic                  cfg_wr;
    logic [REG_ADDR_W-1:0] cfg_addr;
    logic [ADDR_W-1:0]     cfg_wdata;
    logic [ADDR_W-1:0]     cfg_rdata;
    logic                  addr_pop;
    logic                  addr_valid;
    logic [ADDR_W-1:0]     addr_data;

    logic [15:0]       pop_lfsr;
    logic [15:0]       data_lfsr;
    logic              pop_enable;
    int                n_errors;
    int                n_checks;
    int                pop_count;
    int                exp_total;
    logic              exp_resi;
    logic [ADDR_W-1:0] exp_a;
    logic [ADDR_W-1:0] exp_b;
    logic [CNT_W-1:0]  exp_gap;
    logic [CNT_W-1:0]  exp_n;

    idma_rd_addr_top i_idma_rd_addr_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .addr_pop   (addr_pop),
        .addr_valid (addr_valid),
        .addr_data  (addr_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic draw_bits(input int width, output logic [ADDR_W-1:0] value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            data_lfsr = lfsr_step(data_lfsr);
            value = {value[ADDR_W-2:0], data_lfsr[0]};
        end
    endtask

    function automatic logic [ADDR_W-1:0] expected_addr(
        input logic              resi,
        input logic [ADDR_W-1:0] a,
        input logic [ADDR_W-1:0] b,
        input logic [CNT_W-1:0]  gap,
        input logic [CNT_W-1:0]  n,
        input int                index
    );
        logic [ADDR_W-1:0] pair;
        logic [ADDR_W-1:0] offset;
        logic [ADDR_W-1:0] result;
        pair   = resi ? ADDR_W'(index / 2) : ADDR_W'(index);
        offset = pair * {{(ADDR_W-CNT_W){1'b0}}, gap};
        result = a + offset;
        if (resi && (index % 2 == 1)) begin
            result = b + offset;
            // last B of a multi-pair transfer sits one byte further
            if (n >= 2 && pair == ADDR_W'(n) - 1) begin
                result = result + 1;
            end
        end
        return result;
    endfunction

    task automatic timed_out(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic check_value(input string what, input logic [ADDR_W-1:0] got,
                               input logic [ADDR_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED @%0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [ADDR_W-1:0] data);
        @(posedge clk);
        #1;
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #1;
        cfg_wr = 1'b0;
    endtask

    task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, output logic [ADDR_W-1:0] data);
        @(posedge clk);
        #1;
        cfg_addr = addr;
        @(negedge clk);
        data = cfg_rdata;
    endtask

    task automatic set_popping(input logic on);
        @(negedge clk);
        pop_enable = on;
    endtask

    task automatic start_transfer(input logic resi, input logic [ADDR_W-1:0] a,
                                  input logic [ADDR_W-1:0] b, input logic [CNT_W-1:0] gap,
                                  input logic [CNT_W-1:0] n);
        logic [ADDR_W-1:0] rdata;
        @(negedge clk);
        exp_resi  = resi;
        exp_a     = a;
        exp_b     = b;
        exp_gap   = gap;
        exp_n     = n;
        exp_total = resi ? 2 * int'(n) : int'(n);
        pop_count = 0;
        write_reg(REG_FMAPA, a);
        write_reg(REG_FMAPB, b);
        write_reg(REG_GAP, ADDR_W'(gap));
        write_reg(REG_LOOP, ADDR_W'(n));
        write_reg(REG_CTRL, ADDR_W'({resi, 1'b0}));
        read_reg(REG_FMAPA, rdata);
        check_value("fmapA readback", rdata, a);
        read_reg(REG_FMAPB, rdata);
        check_value("fmapB readback", rdata, b);
        read_reg(REG_GAP, rdata);
        check_value("gap readback", rdata, ADDR_W'(gap));
        read_reg(REG_LOOP, rdata);
        check_value("loop readback", rdata, ADDR_W'(n));
        read_reg(REG_CTRL, rdata);
        check_value("mode readback", ADDR_W'(rdata[CTRL_MODE_BIT]), ADDR_W'(resi));
        write_reg(REG_CTRL, ADDR_W'({resi, 1'b1}));
    endtask

    task automatic wait_addr_valid();
        int guard;
        guard = 0;
        while (!addr_valid && guard < WAIT_LIMIT) begin
            @(negedge clk);
            guard++;
        end
        if (!addr_valid) timed_out("no address reached the FIFO");
    endtask

    // all addresses popped, busy low, nothing left behind
    task automatic finish_transfer();
        logic [ADDR_W-1:0] status;
        int                guard;
        logic              leftover;
        guard = 0;
        while (pop_count < exp_total && guard < WAIT_LIMIT) begin
            @(posedge clk);
            guard++;
        end
        if (pop_count < exp_total) timed_out("not all addresses were popped");
        guard  = 0;
        status = '1;
        while (status[STATUS_BUSY_BIT] && guard < WAIT_LIMIT) begin
            read_reg(REG_STATUS, status);
            guard++;
        end
        if (status[STATUS_BUSY_BIT]) timed_out("busy never returned to 0");
        leftover = 1'b0;
        repeat (2 * ADDR_FIFO_DEPTH) begin
            @(negedge clk);
            leftover = leftover | addr_valid;
        end
        check_value("addresses left in FIFO", ADDR_W'(leftover), '0);
        check_value("popped address count", ADDR_W'(pop_count), ADDR_W'(exp_total));
        read_reg(REG_STATUS, status);
        check_value("busy after transfer", ADDR_W'(status[STATUS_BUSY_BIT]), '0);
    endtask

    initial begin
        addr_pop = 1'b0;
        pop_lfsr = 16'd41;
        forever begin
            @(posedge clk);
            #1;
            if (pop_enable) begin
                pop_lfsr = lfsr_step(pop_lfsr);
                addr_pop = pop_lfsr[0];
            end else begin
                addr_pop = 1'b0;
            end
        end
    end

    // pop checker, values seen here are the ones the FIFO pops on this edge
    always @(posedge clk) begin
        if (rst_n && addr_pop && addr_valid) begin
            n_checks++;
            if (pop_count >= exp_total) begin
                n_errors++;
                $display("FAILED @%0t: extra address %h beyond %0d expected", $time, addr_data,
                         exp_total);
            end else if (addr_data !== expected_addr(exp_resi, exp_a, exp_b, exp_gap, exp_n,
                                                     pop_count)) begin
                n_errors++;
                $display("FAILED @%0t: address %0d is %h, expected %h", $time, pop_count,
                         addr_data, expected_addr(exp_resi, exp_a, exp_b, exp_gap, exp_n,
                                                  pop_count));
            end
            pop_count++;
        end
    end

    initial begin
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] b;
        logic [ADDR_W-1:0] gap;
        logic [ADDR_W-1:0] n;
        logic [ADDR_W-1:0] status;
        rst_n      = 1'b0;
        cfg_wr     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        pop_enable = 1'b0;
        data_lfsr  = 16'd41;
        n_errors   = 0;
        n_checks   = 0;
        pop_count  = 0;
        exp_total  = 0;
        exp_resi   = 1'b0;
        exp_a      = '0;
        exp_b      = '0;
        exp_gap    = '0;
        exp_n      = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        @(negedge clk);
        check_value("addr_valid after reset", ADDR_W'(addr_valid), '0);
        read_reg(REG_STATUS, status);
        check_value("busy after reset", ADDR_W'(status[STATUS_BUSY_BIT]), '0);

        // linear walk over fmap A
        set_popping(1'b1);
        draw_bits(32, a);
        draw_bits(32, b);
        draw_bits(16, gap);
        draw_bits(4, n);
        start_transfer(1'b0, a, b, gap[CNT_W-1:0], CNT_W'(n + 1));
        finish_transfer();

        // residual A/B interleave for one pair, two pairs and a random count
        draw_bits(32, a);
        draw_bits(32, b);
        draw_bits(16, gap);
        start_transfer(1'b1, a, b, gap[CNT_W-1:0], 16'd1);
        finish_transfer();
        start_transfer(1'b1, a, b, gap[CNT_W-1:0], 16'd2);
        finish_transfer();
        draw_bits(4, n);
        start_transfer(1'b1, b, a, gap[CNT_W-1:0], CNT_W'(n + 1));
        finish_transfer();

        // back-pressure, generator stalls on a full FIFO
        set_popping(1'b0);
        draw_bits(32, a);
        draw_bits(32, b);
        draw_bits(16, gap);
        start_transfer(1'b1, a, b, gap[CNT_W-1:0], 16'd10);
        wait_addr_valid();
        repeat (4 * ADDR_FIFO_DEPTH) @(posedge clk);
        @(negedge clk);
        check_value("FIFO fill under back-pressure",
                    ADDR_W'(i_idma_rd_addr_top.i_addr_fifo.count), ADDR_W'(ADDR_FIFO_DEPTH));
        read_reg(REG_STATUS, status);
        check_value("busy while stalled", ADDR_W'(status[STATUS_BUSY_BIT]), 32'd1);
        set_popping(1'b1);
        finish_transfer();

        // second start while busy is dropped, mode stays linear
        set_popping(1'b0);
        draw_bits(32, a);
        draw_bits(16, gap);
        start_transfer(1'b0, a, b, gap[CNT_W-1:0], 16'd12);
        wait_addr_valid();
        write_reg(REG_CTRL, ADDR_W'({1'b1, 1'b1}));
        set_popping(1'b1);
        finish_transfer();
        read_reg(REG_CTRL, status);
        check_value("mode after dropped start", ADDR_W'(status[CTRL_MODE_BIT]), '0);

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== idma_rd.f ====
design/idma_rd_pkg.sv
design/idma_rd_cfg_regs.sv
design/idma_rd_sync_resi_raddr_gen.sv
design/idma_rd_lin_raddr_gen.sv
design/idma_rd_addr_fifo.sv
design/idma_rd_addr_top.sv
dv/idma_rd_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the address front end testbench, result is read from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module idma_rd_tb -f idma_rd.f \
    && ./obj_dir/Vidma_rd_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation reported failure"; exit 1; }
echo "simulation finished without failure"
exit 0
